// File: qbank.f
+incdir+design
design/qbank_pkg.sv
design/qbank_fifo_ctrl.sv
design/qbank_fifo.sv
design/qbank_dispatch.sv
design/qbank_drain_arb.sv
design/qbank_top.sv
verif/qbank_props.sv
verif/qbank_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the queue bank testbench with verilator.
# exit status is nonzero when the run fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -j 0 \
  -f qbank.f --top-module qbank_tb -o qbank_sim > build.log 2>&1 \
  && ./obj_dir/qbank_sim > "$LOG" 2>&1 \
  || { echo "build or simulation error, see build.log and $LOG"; exit 1; }

grep -q '\*\*\* FAILED \*\*\*' "$LOG" \
  && { echo "simulation failed, see $LOG"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' "$LOG" \
  || { echo "no result line in $LOG"; exit 1; }
echo "simulation passed"

// File: verif/qbank_tb.sv
//**************************************************
// queue bank testbench.
// clock, reset, directed tests, compare tasks, timeout.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_tb import qbank_pkg::*; ();

  localparam int MAX_CYCLES = 2000;  // tests need a few hundred cycles.

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_in_valid;
  logic                    o_in_ready;
  qb_op_e                  i_in_op;
  qb_chan_t                i_in_chan;
  qb_data_t                i_in_data;
  logic                    o_out_valid;
  logic                    i_out_ready;
  qb_chan_t                o_out_chan;
  qb_data_t                o_out_data;
  logic [`QB_CHANNELS-1:0] o_almost_full;

  qb_data_t ref_q [`QB_CHANNELS][$];  // expected words per channel.
  qb_chan_t chan_log [$];             // channel of each word that left.
  integer   seed;
  int       err_count;
  int       check_count;
  int       cycles = 0;

  qbank_top dut0 (.*);

  bind qbank_top qbank_props u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_in_op     (i_in_op),
    .i_in_chan   (i_in_chan),
    .i_in_ready  (o_in_ready),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_chan  (o_out_chan),
    .i_out_data  (o_out_data),
    .i_push      (push),
    .i_flush     (flush),
    .i_pop       (pop)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;  // 4 ns period.

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped at the cycle limit of %0d, DUT did not finish", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_data(input qb_data_t got, input qb_data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_chan(input qb_chan_t got, input qb_chan_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input logic [`QB_CHANNELS-1:0] got,
                             input logic [`QB_CHANNELS-1:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_number(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // one word leaves the slot, compared with its channel queue.
  task automatic receive_word();
    chan_log.push_back(o_out_chan);
    if (ref_q[o_out_chan].size() == 0) begin
      err_count++;
      $display("ERROR at %0t ns: unexpected word %h on channel %0d", $time, o_out_data,
               o_out_chan);
    end else begin
      check_data(o_out_data, ref_q[o_out_chan].pop_front(), "output data");
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst_n && o_out_valid && i_out_ready) begin
      receive_word();
    end
  end

  function automatic int pending_words();
    int n;
    n = 0;
    for (int ch = 0; ch < `QB_CHANNELS; ch++) begin
      n += ref_q[ch].size();
    end
    return n;
  endfunction

  task automatic push_word(input qb_chan_t ch, input qb_data_t d, output logic accepted);
    @(negedge i_clk);
    i_in_valid = 1'b1;
    i_in_op    = OP_PUSH;
    i_in_chan  = ch;
    i_in_data  = d;
    @(posedge i_clk);
    accepted = o_in_ready;  // taken at this edge.
    if (accepted) begin
      ref_q[ch].push_back(d);
    end
  endtask

  task automatic flush_chan(input qb_chan_t ch);
    @(negedge i_clk);
    i_in_valid = 1'b1;
    i_in_op    = OP_FLUSH;
    i_in_chan  = ch;
    @(posedge i_clk);
    check_level(o_in_ready, 1'b1, "ready during flush");
  endtask

  task automatic idle_input();
    @(negedge i_clk);
    i_in_valid = 1'b0;
  endtask

  task automatic set_ready(input logic rdy);
    @(negedge i_clk);
    i_out_ready = rdy;
  endtask

  task automatic wait_drained();
    while (pending_words() != 0 || o_out_valid) begin
      @(negedge i_clk);
    end
  endtask

  task automatic test_single_order();
    logic acc;
    int   n_acc;
    n_acc = 0;
    chan_log.delete();
    set_ready(1'b1);
    for (int i = 0; i < 8; i++) begin
      push_word(2'd2, qb_data_t'($random(seed)), acc);
      n_acc += int'(acc);
    end
    idle_input();
    wait_drained();
    check_number(n_acc, 8, "single channel words taken");
    check_number(chan_log.size(), 8, "single channel words out");
    foreach (chan_log[i]) begin
      check_chan(chan_log[i], 2'd2, "single channel output channel");
    end
  endtask

  task automatic test_full_backpressure();
    logic acc;
    int   n_acc;
    n_acc = 0;
    acc   = 1'b1;
    chan_log.delete();
    set_ready(1'b0);
    while (acc && n_acc < 2 * `QB_DEPTH) begin
      push_word(2'd1, qb_data_t'($random(seed)), acc);
      n_acc += int'(acc);
    end
    idle_input();
    check_number(n_acc, `QB_DEPTH + 1, "words taken before ready fell");  // fifo plus slot.
    set_ready(1'b1);
    wait_drained();
    check_number(chan_log.size(), `QB_DEPTH + 1, "words drained after stall");
  endtask

  task automatic test_round_robin();
    logic acc;
    chan_log.delete();
    set_ready(1'b0);
    for (int ch = 0; ch < `QB_CHANNELS; ch++) begin
      for (int k = 0; k < 2; k++) begin
        push_word(qb_chan_t'(ch), qb_data_t'($random(seed)), acc);
      end
    end
    idle_input();
    set_ready(1'b1);
    wait_drained();
    check_number(chan_log.size(), 2 * `QB_CHANNELS, "round robin words out");
    foreach (chan_log[i]) begin
      check_chan(chan_log[i], qb_chan_t'(i % `QB_CHANNELS), "round robin order");
    end
  endtask

  task automatic test_almost_full();
    logic                    acc;
    logic [`QB_CHANNELS-1:0] exp_flags;
    set_ready(1'b0);
    for (int n = 1; n <= `QB_DEPTH; n++) begin
      push_word(2'd3, qb_data_t'($random(seed)), acc);
      idle_input();
      @(posedge i_clk);
      @(negedge i_clk);
      exp_flags    = '0;
      exp_flags[3] = ((n - 1) >= `QB_AF_LEVEL);  // first word sits in the slot.
      check_flags(o_almost_full, exp_flags, "almost-full while filling");
    end
    set_ready(1'b1);
    wait_drained();
    check_flags(o_almost_full, '0, "almost-full after drain");
  endtask

  task automatic test_flush();
    logic acc;
    chan_log.delete();
    set_ready(1'b0);
    for (int i = 0; i < 5; i++) begin
      push_word(2'd0, qb_data_t'($random(seed)), acc);
    end
    flush_chan(2'd0);
    idle_input();
    // only the head word in the slot survives.
    while (ref_q[0].size() > 1) begin
      ref_q[0].delete(ref_q[0].size() - 1);
    end
    check_flags(o_almost_full, '0, "almost-full after flush");
    set_ready(1'b1);
    wait_drained();
    repeat (10) @(negedge i_clk);
    check_number(chan_log.size(), 1, "words out after flush");
    push_word(2'd0, qb_data_t'($random(seed)), acc);
    idle_input();
    wait_drained();
    check_number(chan_log.size(), 2, "words out after new push");
  endtask

  initial begin
    seed        = 71097;
    err_count   = 0;
    check_count = 0;
    i_rst_n     = 1'b0;
    i_in_valid  = 1'b0;
    i_in_op     = OP_PUSH;
    i_in_chan   = '0;
    i_in_data   = '0;
    i_out_ready = 1'b0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    check_level(o_out_valid, 1'b0, "valid after reset");
    check_level(o_in_ready, 1'b1, "ready after reset");
    check_flags(o_almost_full, '0, "almost-full after reset");
    test_single_order();
    test_full_backpressure();
    test_round_robin();
    test_almost_full();
    test_flush();
    $display("checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/qbank_props.sv
//**************************************************
// queue bank handshake assertions.
// output hold, input ready and pop-on-empty checks.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_props import qbank_pkg::*; (
  input logic                    i_clk,
  input logic                    i_rst_n,
  input qb_op_e                  i_in_op,
  input qb_chan_t                i_in_chan,
  input logic                    i_in_ready,
  input logic                    i_out_valid,
  input logic                    i_out_ready,
  input qb_chan_t                i_out_chan,
  input qb_data_t                i_out_data,
  input logic [`QB_CHANNELS-1:0] i_push,
  input logic [`QB_CHANNELS-1:0] i_flush,
  input logic [`QB_CHANNELS-1:0] i_pop
);

  qb_slot_e                slot;
  qb_count_t               occ [`QB_CHANNELS];  // words held per channel, slot excluded.
  logic [`QB_CHANNELS-1:0] held;

  assign slot = i_out_valid ? SLOT_FULL : SLOT_EMPTY;  // slot state seen from outside.

  // occupancy rebuilt from the push, pop and flush strobes.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int ch = 0; ch < `QB_CHANNELS; ch++) begin
        occ[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `QB_CHANNELS; ch++) begin
        if (i_flush[ch]) begin
          occ[ch] <= '0;
        end else begin
          occ[ch] <= occ[ch] + qb_count_t'(i_push[ch]) - qb_count_t'(i_pop[ch]);
        end
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < `QB_CHANNELS; ch++) begin
      held[ch] = (occ[ch] != '0);
    end
  end

  // a stalled word holds its place.
  a_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (slot == SLOT_FULL && !i_out_ready) |=>
      (slot == SLOT_FULL && $stable(i_out_chan) && $stable(i_out_data)))
    else $error("output slot changed while the consumer stalled");

  a_push_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_in_op == OP_PUSH && occ[i_in_chan] < qb_count_t'(`QB_DEPTH)) |-> i_in_ready)
    else $error("push refused although the target fifo has room");

  // pops only go to channels holding data.
  a_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_pop & ~held) == '0)
    else $error("arbiter popped an empty channel");

endmodule

// File: design/qbank_top.sv
//**************************************************
// queue bank top level.
// dispatcher, four fifo channels and drain arbiter.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_top import qbank_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_in_valid,
  output logic                    o_in_ready,
  input  qb_op_e                  i_in_op,
  input  qb_chan_t                i_in_chan,
  input  qb_data_t                i_in_data,
  output logic                    o_out_valid,
  input  logic                    i_out_ready,
  output qb_chan_t                o_out_chan,
  output qb_data_t                o_out_data,
  output logic [`QB_CHANNELS-1:0] o_almost_full
);

  logic [`QB_CHANNELS-1:0] push;
  logic [`QB_CHANNELS-1:0] flush;
  logic [`QB_CHANNELS-1:0] pop;
  logic [`QB_CHANNELS-1:0] empty;
  logic [`QB_CHANNELS-1:0] full;
  qb_data_t                fifo_data [`QB_CHANNELS];

  qbank_dispatch u_dispatch (
    .i_in_valid (i_in_valid),
    .i_in_op    (i_in_op),
    .i_in_chan  (i_in_chan),
    .o_in_ready (o_in_ready),
    .i_full     (full),
    .o_push     (push),
    .o_flush    (flush)
  );

  // input data fans out, the push strobe picks the channel.
  for (genvar ch = 0; ch < `QB_CHANNELS; ch++) begin : g_fifo
    qbank_fifo u_fifo (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push        (push[ch]),
      .i_pop         (pop[ch]),
      .i_flush       (flush[ch]),
      .i_data        (i_in_data),
      .o_data        (fifo_data[ch]),
      .o_empty       (empty[ch]),
      .o_full        (full[ch]),
      .o_almost_full (o_almost_full[ch])
    );
  end

  qbank_drain_arb u_arb (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_empty     (empty),
    .i_fifo_data (fifo_data),
    .o_pop       (pop),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_chan  (o_out_chan),
    .o_out_data  (o_out_data)
  );

endmodule

// File: design/qbank_drain_arb.sv
//**************************************************
// round-robin drain arbiter.
// pops non-empty fifos into one registered output slot.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_drain_arb import qbank_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic [`QB_CHANNELS-1:0] i_empty,
  input  qb_data_t                i_fifo_data [`QB_CHANNELS],
  output logic [`QB_CHANNELS-1:0] o_pop,
  output logic                    o_out_valid,
  input  logic                    i_out_ready,
  output qb_chan_t                o_out_chan,
  output qb_data_t                o_out_data
);

  qb_slot_e slot_state;
  qb_chan_t last_grant;
  qb_chan_t win;
  logic     found;
  logic     can_load;
  logic     grant;

  // search from the channel after the last grant, wrapping.
  always_comb begin
    qb_chan_t cand;
    found = 1'b0;
    win   = last_grant;
    for (int i = 1; i <= `QB_CHANNELS; i++) begin
      cand = qb_chan_t'(last_grant + i);
      if (!found && !i_empty[cand]) begin
        found = 1'b1;
        win   = cand;
      end
    end
  end

  assign can_load = (slot_state == SLOT_EMPTY) || i_out_ready;  // empty or leaving now.
  assign grant    = found && can_load;

  always_comb begin
    o_pop = '0;
    if (grant) begin
      o_pop[win] = 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slot_state <= SLOT_EMPTY;
      last_grant <= qb_chan_t'(`QB_CHANNELS - 1);  // channel 0 goes first.
    end else if (grant) begin
      slot_state <= SLOT_FULL;
      last_grant <= win;
    end else if (i_out_ready) begin
      slot_state <= SLOT_EMPTY;
    end
  end

  // slot payload, held while the consumer stalls.
  always_ff @(posedge i_clk) begin
    if (grant) begin
      o_out_chan <= win;
      o_out_data <= i_fifo_data[win];
    end
  end

  assign o_out_valid = (slot_state == SLOT_FULL);

endmodule

// File: design/qbank_dispatch.sv
//**************************************************
// input command dispatcher.
// per-channel push and flush strobes, input ready.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_dispatch import qbank_pkg::*; (
  input  logic                    i_in_valid,
  input  qb_op_e                  i_in_op,
  input  qb_chan_t                i_in_chan,
  output logic                    o_in_ready,
  input  logic [`QB_CHANNELS-1:0] i_full,
  output logic [`QB_CHANNELS-1:0] o_push,
  output logic [`QB_CHANNELS-1:0] o_flush
);

  logic is_push;
  logic push_blocked;

  assign is_push      = (i_in_op == OP_PUSH);
  assign push_blocked = is_push && i_full[i_in_chan];  // target fifo full.

  // flush is always taken.
  assign o_in_ready = !push_blocked;

  always_comb begin
    o_push  = '0;
    o_flush = '0;
    if (i_in_valid) begin
      if (is_push) begin
        // the full check lives here only.
        o_push[i_in_chan] = !push_blocked;
      end else begin
        o_flush[i_in_chan] = 1'b1;
      end
    end
  end

endmodule

// File: design/qbank_fifo.sv
//**************************************************
// one fifo channel.
// controller, storage array and registered head word.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_fifo import qbank_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_push,
  input  logic     i_pop,
  input  logic     i_flush,
  input  qb_data_t i_data,
  output qb_data_t o_data,
  output logic     o_empty,
  output logic     o_full,
  output logic     o_almost_full
);

  localparam int RAM_WORDS = `QB_DEPTH - 1;

  logic [2:0] write_ptr;
  logic [2:0] read_ptr;
  logic       write_to_ff;
  logic       write_to_ram;
  logic       read_from_ram;
  qb_data_t   mem [RAM_WORDS];
  qb_data_t   ram_rd_data;

  qbank_fifo_ctrl u_ctrl (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_push          (i_push),
    .i_pop           (i_pop),
    .i_flush         (i_flush),
    .o_empty         (o_empty),
    .o_full          (o_full),
    .o_almost_full   (o_almost_full),
    .o_word_count    (),
    .o_write_ptr     (write_ptr),
    .o_read_ptr      (read_ptr),
    .o_write_to_ff   (write_to_ff),
    .o_write_to_ram  (write_to_ram),
    .o_read_from_ram (read_from_ram)
  );

  // storage, written at the tail.
  always_ff @(posedge i_clk) begin
    if (write_to_ram) begin
      mem[write_ptr] <= i_data;
    end
  end

  assign ram_rd_data = mem[read_ptr];  // async read at the next-to-head slot.

  // head word register.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data <= '0;
    end else if (i_flush) begin
      o_data <= '0;
    end else if (write_to_ff) begin
      o_data <= i_data;
    end else if (read_from_ram) begin
      o_data <= ram_rd_data;
    end
  end

endmodule

// File: design/qbank_fifo_ctrl.sv
//**************************************************
// fifo controller with count, pointers and flags.
// steers words between storage and output register.
//**************************************************
`timescale 1ns/10ps
`include "qbank_consts.svh"

module qbank_fifo_ctrl import qbank_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_push,
  input  logic       i_pop,
  input  logic       i_flush,
  output logic       o_empty,
  output logic       o_full,
  output logic       o_almost_full,
  output qb_count_t  o_word_count,
  output logic [2:0] o_write_ptr,
  output logic [2:0] o_read_ptr,
  output logic       o_write_to_ff,
  output logic       o_write_to_ram,
  output logic       o_read_from_ram
);

  // one word lives in the output register, the rest in storage.
  localparam int RAM_WORDS = `QB_DEPTH - 1;

  qb_count_t next_count;

  function automatic logic [2:0] ptr_inc(input logic [2:0] ptr);
    return (ptr == 3'(RAM_WORDS - 1)) ? 3'd0 : ptr + 3'd1;
  endfunction

  always_comb begin
    next_count      = o_word_count;
    o_write_to_ff   = 1'b0;
    o_write_to_ram  = 1'b0;
    o_read_from_ram = 1'b0;
    if (i_flush) begin
      next_count = '0;  // flush wins over push and pop.
    end else if (i_push && !i_pop) begin
      next_count = o_word_count + qb_count_t'(1);
      if (o_word_count == '0) begin
        o_write_to_ff = 1'b1;  // empty, bypass storage.
      end else begin
        o_write_to_ram = 1'b1;
      end
    end else if (!i_push && i_pop) begin
      next_count = o_word_count - qb_count_t'(1);
      o_read_from_ram = (o_word_count > qb_count_t'(1));  // refill head.
    end else if (i_push && i_pop) begin
      // last word leaving, new word goes straight to the head.
      if (o_word_count == qb_count_t'(1)) begin
        o_write_to_ff = 1'b1;
      end else begin
        o_write_to_ram  = 1'b1;
        o_read_from_ram = 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_word_count  <= '0;
      o_write_ptr   <= '0;
      o_read_ptr    <= '0;
      o_empty       <= 1'b1;
      o_full        <= 1'b0;
      o_almost_full <= 1'b0;
    end else begin
      o_word_count  <= next_count;
      o_empty       <= (next_count == '0);
      o_full        <= (next_count == qb_count_t'(`QB_DEPTH));
      o_almost_full <= (next_count >= qb_count_t'(`QB_AF_LEVEL));
      if (i_flush) begin
        o_write_ptr <= '0;
        o_read_ptr  <= '0;
      end else begin
        if (o_write_to_ram) begin
          o_write_ptr <= ptr_inc(o_write_ptr);
        end
        if (o_read_from_ram) begin
          o_read_ptr <= ptr_inc(o_read_ptr);
        end
      end
    end
  end

endmodule

// File: design/qbank_pkg.sv
//**************************************************
// queue bank shared types.
// data, channel and count types, opcode and slot enums.
//**************************************************
`include "qbank_consts.svh"

package qbank_pkg;

  // one data word.
  typedef logic [`QB_DATA_W-1:0] qb_data_t;

  typedef logic [1:0] qb_chan_t;  // channel number.

  // word count, 0 to depth inclusive.
  typedef logic [$clog2(`QB_DEPTH+1)-1:0] qb_count_t;

  // input command opcode.
  typedef enum logic {
    OP_PUSH  = 1'b0,
    OP_FLUSH = 1'b1
  } qb_op_e;

  // output slot state of the drain arbiter.
  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } qb_slot_e;

endpackage

// File: design/qbank_consts.svh
//**************************************************
// queue bank sizing macros.
// channel count, depth, data width, almost-full level.
//**************************************************
`ifndef QBANK_CONSTS_SVH
`define QBANK_CONSTS_SVH

// number of fifo channels.
`define QB_CHANNELS 4

`define QB_DEPTH 8     // words per fifo, output register included.

`define QB_DATA_W 16   // data word width.

`define QB_AF_LEVEL 6  // almost-full at or above this count.

`endif
